// File: ll_pkg.sv
/*
  Logic link shared definitions
  Datapath and register widths, receive FIFO sizing, the register map,
  status field positions and the register-block FSM encodings
*/
`default_nettype none

package ll_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath sizing
  ////////////////////////////////////////////////////////////

  // User and link word width
  localparam int DATA_WIDTH = 32;
  // Receive FIFO entries, must be a power of two
  localparam int FIFO_DEPTH = 16;
  // The fill count needs one extra bit so it can reach FIFO_DEPTH
  localparam int FIFO_COUNT_MSB = $clog2(FIFO_DEPTH);
  localparam int CREDIT_WIDTH = 6;
  // One credit per receive FIFO entry
  localparam logic [CREDIT_WIDTH-1:0] RESET_CREDIT = CREDIT_WIDTH'(FIFO_DEPTH);

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  localparam int ADDR_WIDTH = 2;
  localparam int REG_WIDTH = 32;
  localparam logic [ADDR_WIDTH-1:0] REG_CTRL = 2'd0;
  localparam logic [ADDR_WIDTH-1:0] REG_CREDIT = 2'd1;
  // Read only, a write clears the sticky overflow flag
  localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 2'd2;

  // Status word layout
  localparam int STAT_CREDIT_LSB = 0;
  localparam int STAT_FILL_LSB = 8;
  localparam int STAT_OVF_BIT = 16;

  // Register block handshake states
  localparam int CFG_ST_WIDTH = 2;
  localparam logic [CFG_ST_WIDTH-1:0] CFG_ST_IDLE = 2'd0;
  localparam logic [CFG_ST_WIDTH-1:0] CFG_ST_CAPT = 2'd1;
  localparam logic [CFG_ST_WIDTH-1:0] CFG_ST_ACK = 2'd2;

endpackage

`default_nettype wire

// File: ll_tx_ctrl.sv
/*
  Logic link transmit controller
  Gates the upstream ready with a credit count, registers each accepted
  word onto the link and tracks credits returned by the receiver
*/
`default_nettype none

module ll_tx_ctrl (
  input  logic                            clk_wr,
  input  logic                            rst_wr_n,
  // Upstream user
  input  logic                            user_o_valid,
  input  logic [ll_pkg::DATA_WIDTH-1:0]   user_o_data,
  output logic                            user_o_ready,
  // Configuration block
  input  logic                            link_en,
  input  logic [ll_pkg::CREDIT_WIDTH-1:0] credit_init,
  output logic [ll_pkg::CREDIT_WIDTH-1:0] credit_count,
  // Credit return from the receive side
  input  logic                            tx_credit,
  // Link towards the receive FIFO
  output logic                            link_push,
  output logic [ll_pkg::DATA_WIDTH-1:0]   link_data
);

  logic accept;

  // Words may only be taken while the link is up and the far side has room
  assign user_o_ready = link_en & (credit_count != '0);
  assign accept = user_o_valid & user_o_ready;

  ////////////////////////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////////////////////////

  // While the link is down the counter follows the programmed value,
  // so enabling the link starts from a fresh credit pool
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      credit_count <= ll_pkg::RESET_CREDIT;
    end else if (!link_en) begin
      credit_count <= credit_init;
    end else if (accept && !tx_credit) begin
      credit_count <= credit_count - 1'b1;
    end else if (tx_credit && !accept) begin
      credit_count <= credit_count + 1'b1;
    end
    // An accept and a returned credit in the same cycle cancel out
  end

  ////////////////////////////////////////////////////////////
  // Link output register
  ////////////////////////////////////////////////////////////

  // The push strobe follows each accept by one cycle
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      link_push <= 1'b0;
    end else begin
      link_push <= accept;
    end
  end

  // Link data changes only on an accept and is qualified by link_push
  always_ff @(posedge clk_wr) begin
    if (accept) begin
      link_data <= user_o_data;
    end
  end

  // More returns than pushes would wrap a full pool back to zero
  a_credit_no_overflow : assert property (
    @(posedge clk_wr) disable iff (!rst_wr_n)
    (link_en && credit_count == '1) |=> (!link_en || credit_count != '0)
  ) else $error("credit counter wrapped past its maximum");

endmodule

`default_nettype wire

// File: ll_rx_fifo.sv
/*
  Logic link receive FIFO
  Circular buffer in a RAM with a registered read port, a fill count
  for status and corner-case detection, and a one-cycle overflow pulse
*/
`default_nettype none

module ll_rx_fifo #(
  parameter int FIFO_COUNT_MSB = ll_pkg::FIFO_COUNT_MSB
) (
  input  logic                          clk_wr,
  input  logic                          rst_wr_n,
  input  logic                          push,
  input  logic [ll_pkg::DATA_WIDTH-1:0] wdata,
  input  logic                          pop,
  output logic [ll_pkg::DATA_WIDTH-1:0] rdata,
  output logic                          empty,
  output logic [FIFO_COUNT_MSB:0]       numfilled,
  output logic                          overflow
);

  // Depth follows from the count width so pointers wrap on their own
  localparam int DEPTH = 1 << FIFO_COUNT_MSB;
  localparam logic [FIFO_COUNT_MSB:0] FULL_COUNT = (FIFO_COUNT_MSB + 1)'(DEPTH);

  logic [ll_pkg::DATA_WIDTH-1:0] mem [DEPTH];
  logic [FIFO_COUNT_MSB-1:0]     wr_ptr;
  logic [FIFO_COUNT_MSB-1:0]     rd_ptr;
  logic [FIFO_COUNT_MSB-1:0]     rd_ptr_next;
  logic                          full;
  logic                          wr_en;
  logic                          rd_en;

  assign empty = (numfilled == '0);
  assign full = (numfilled == FULL_COUNT);

  // A push into a full FIFO is lost, the overflow pulse reports it
  assign wr_en = push & ~full;
  assign rd_en = pop & ~empty;

  // Head address for the coming cycle, used to prefetch the RAM
  always_comb begin
    rd_ptr_next = rd_ptr;
    if (rd_en) begin
      rd_ptr_next = rd_ptr + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers and fill count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      numfilled <= '0;
      overflow  <= 1'b0;
    end else begin
      rd_ptr   <= rd_ptr_next;
      overflow <= push & full;
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        numfilled <= numfilled + 1'b1;
      end else if (rd_en && !wr_en) begin
        numfilled <= numfilled - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // The read has no write-through. When the head is written in the
  // same cycle it is read, rdata holds old content for one cycle and
  // the receive controller masks that cycle
  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= wdata;
    end
    rdata <= mem[rd_ptr_next];
  end

  // The receive controller must never pop an empty FIFO
  a_no_pop_when_empty : assert property (
    @(posedge clk_wr) disable iff (!rst_wr_n)
    !(pop && empty)
  ) else $error("pop while receive FIFO empty");

endmodule

`default_nettype wire

// File: ll_rx_ctrl.sv
/*
  Logic link receive controller
  Derives a safe downstream valid from the FIFO empty flag, pops
  on each downstream handshake and returns one credit per pop
*/
`default_nettype none

module ll_rx_ctrl #(
  parameter int FIFO_COUNT_MSB = ll_pkg::FIFO_COUNT_MSB
) (
  input  logic                    clk_wr,
  input  logic                    rst_wr_n,
  // Downstream user
  output logic                    user_i_valid,
  input  logic                    user_i_ready,
  // Receive FIFO
  output logic                    rxfifo_i_pop,
  input  logic                    rxfifo_i_empty,
  input  logic [FIFO_COUNT_MSB:0] dbg_rxfifo_i_numfilled,
  input  logic                    rxfifo_i_push,
  // Credit return towards the transmitter
  output logic                    tx_i_credit
);

  localparam logic [FIFO_COUNT_MSB:0] ONE_ENTRY = {{FIFO_COUNT_MSB{1'b0}}, 1'b1};

  logic rxfifo_corner_case;
  logic rxfifo_i_empty_dly;

  // The RAM read is registered. With a single entry, a push and a pop
  // in one cycle make the next head the address being written, and
  // its read data is not there until one cycle later
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      rxfifo_corner_case <= 1'b0;
    end else begin
      rxfifo_corner_case <= rxfifo_i_push & rxfifo_i_pop &
                            (dbg_rxfifo_i_numfilled == ONE_ENTRY);
    end
  end

  // The first word into an empty FIFO also needs one extra cycle
  // before the registered read shows it
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      rxfifo_i_empty_dly <= 1'b1;
    end else begin
      rxfifo_i_empty_dly <= rxfifo_i_empty;
    end
  end

  assign user_i_valid = ~rxfifo_i_empty & ~rxfifo_i_empty_dly & ~rxfifo_corner_case;

  // Each word handed downstream frees one FIFO entry on the far side
  assign rxfifo_i_pop = user_i_valid & user_i_ready;
  assign tx_i_credit = rxfifo_i_pop;

endmodule

`default_nettype wire

// File: ll_cfg_regs.sv
/*
  Logic link configuration registers
  Four-phase req/ack register port holding the link enable and the
  initial credit count, and reporting credits, fill level and overflow
*/
`default_nettype none

module ll_cfg_regs (
  input  logic                              clk_wr,
  input  logic                              rst_wr_n,
  // Register host
  input  logic                              cfg_req,
  input  logic                              cfg_wr,
  input  logic [ll_pkg::ADDR_WIDTH-1:0]     cfg_addr,
  input  logic [ll_pkg::REG_WIDTH-1:0]      cfg_wdata,
  output logic                              cfg_ack,
  output logic [ll_pkg::REG_WIDTH-1:0]      cfg_rdata,
  // Status sources
  input  logic [ll_pkg::CREDIT_WIDTH-1:0]   credit_count,
  input  logic [ll_pkg::FIFO_COUNT_MSB:0]   rxfifo_numfilled,
  input  logic                              rxfifo_overflow,
  // Control towards the transmit controller
  output logic                              link_en,
  output logic [ll_pkg::CREDIT_WIDTH-1:0]   credit_init
);

  logic [ll_pkg::CFG_ST_WIDTH-1:0] state;
  logic                            cap_wr;
  logic [ll_pkg::ADDR_WIDTH-1:0]   cap_addr;
  logic [ll_pkg::REG_WIDTH-1:0]    cap_wdata;
  logic [ll_pkg::REG_WIDTH-1:0]    rd_word;
  logic                            ovf_sticky;
  logic                            do_access;

  assign cfg_ack = (state == ll_pkg::CFG_ST_ACK);
  // The access itself happens on the edge that raises ack
  assign do_access = (state == ll_pkg::CFG_ST_CAPT);

  // Read mux on the captured address
  always_comb begin
    rd_word = '0;
    case (cap_addr)
      ll_pkg::REG_CTRL: rd_word[0] = link_en;
      ll_pkg::REG_CREDIT: rd_word[ll_pkg::CREDIT_WIDTH-1:0] = credit_init;
      ll_pkg::REG_STATUS: begin
        rd_word[ll_pkg::STAT_CREDIT_LSB +: ll_pkg::CREDIT_WIDTH] = credit_count;
        rd_word[ll_pkg::STAT_FILL_LSB +: ll_pkg::FIFO_COUNT_MSB + 1] = rxfifo_numfilled;
        rd_word[ll_pkg::STAT_OVF_BIT] = ovf_sticky;
      end
      default: rd_word = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Handshake FSM and registers
  ////////////////////////////////////////////////////////////

  // Idle sees req and captures, capture does the access and raises
  // ack, and ack holds until the host drops req
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      state       <= ll_pkg::CFG_ST_IDLE;
      link_en     <= 1'b0;
      credit_init <= ll_pkg::RESET_CREDIT;
      ovf_sticky  <= 1'b0;
    end else begin
      case (state)
        ll_pkg::CFG_ST_IDLE: if (cfg_req) state <= ll_pkg::CFG_ST_CAPT;
        ll_pkg::CFG_ST_CAPT: state <= ll_pkg::CFG_ST_ACK;
        ll_pkg::CFG_ST_ACK: if (!cfg_req) state <= ll_pkg::CFG_ST_IDLE;
        default: state <= ll_pkg::CFG_ST_IDLE;
      endcase
      if (do_access && cap_wr) begin
        case (cap_addr)
          ll_pkg::REG_CTRL: link_en <= cap_wdata[0];
          ll_pkg::REG_CREDIT: credit_init <= cap_wdata[ll_pkg::CREDIT_WIDTH-1:0];
          ll_pkg::REG_STATUS: ovf_sticky <= 1'b0;
          default: ;
        endcase
      end
      // A new overflow wins over a clear in the same cycle
      if (rxfifo_overflow) begin
        ovf_sticky <= 1'b1;
      end
    end
  end

  // Host fields and read data are plain payload
  always_ff @(posedge clk_wr) begin
    if (state == ll_pkg::CFG_ST_IDLE && cfg_req) begin
      cap_wr    <= cfg_wr;
      cap_addr  <= cfg_addr;
      cap_wdata <= cfg_wdata;
    end
    if (do_access) begin
      cfg_rdata <= rd_word;
    end
  end

  // The host may only withdraw a request once it has been acknowledged
  a_req_held_until_ack : assert property (
    @(posedge clk_wr) disable iff (!rst_wr_n)
    $fell(cfg_req) |-> $past(cfg_ack)
  ) else $error("cfg_req dropped before cfg_ack");

endmodule

`default_nettype wire

// File: ll_link_top.sv
/*
  Logic link top level
  Loops the transmit controller into the receive FIFO and controller
  on one clock, with the configuration block beside the transmitter
*/
`default_nettype none

module ll_link_top (
  input  logic                            clk_wr,
  input  logic                            rst_wr_n,
  // Upstream user
  input  logic                            user_o_valid,
  input  logic [ll_pkg::DATA_WIDTH-1:0]   user_o_data,
  output logic                            user_o_ready,
  // Downstream user
  output logic                            user_i_valid,
  output logic [ll_pkg::DATA_WIDTH-1:0]   user_i_data,
  input  logic                            user_i_ready,
  // Register host
  input  logic                            cfg_req,
  input  logic                            cfg_wr,
  input  logic [ll_pkg::ADDR_WIDTH-1:0]   cfg_addr,
  input  logic [ll_pkg::REG_WIDTH-1:0]    cfg_wdata,
  output logic                            cfg_ack,
  output logic [ll_pkg::REG_WIDTH-1:0]    cfg_rdata
);

  // Link between transmitter and receive FIFO
  logic                            link_push;
  logic [ll_pkg::DATA_WIDTH-1:0]   link_data;
  // Receive side
  logic                            rxfifo_empty;
  logic                            rxfifo_pop;
  logic                            rxfifo_overflow;
  logic [ll_pkg::FIFO_COUNT_MSB:0] rxfifo_numfilled;
  logic                            tx_credit;
  // Configuration
  logic                            link_en;
  logic [ll_pkg::CREDIT_WIDTH-1:0] credit_init;
  logic [ll_pkg::CREDIT_WIDTH-1:0] credit_count;

  ll_tx_ctrl i_tx_ctrl (
    .clk_wr       (clk_wr),
    .rst_wr_n     (rst_wr_n),
    .user_o_valid (user_o_valid),
    .user_o_data  (user_o_data),
    .user_o_ready (user_o_ready),
    .link_en      (link_en),
    .credit_init  (credit_init),
    .credit_count (credit_count),
    .tx_credit    (tx_credit),
    .link_push    (link_push),
    .link_data    (link_data)
  );

  ll_rx_fifo #(.FIFO_COUNT_MSB(ll_pkg::FIFO_COUNT_MSB)) i_rx_fifo (
    .clk_wr    (clk_wr),
    .rst_wr_n  (rst_wr_n),
    .push      (link_push),
    .wdata     (link_data),
    .pop       (rxfifo_pop),
    .rdata     (user_i_data),
    .empty     (rxfifo_empty),
    .numfilled (rxfifo_numfilled),
    .overflow  (rxfifo_overflow)
  );

  ll_rx_ctrl #(.FIFO_COUNT_MSB(ll_pkg::FIFO_COUNT_MSB)) i_rx_ctrl (
    .clk_wr                 (clk_wr),
    .rst_wr_n               (rst_wr_n),
    .user_i_valid           (user_i_valid),
    .user_i_ready           (user_i_ready),
    .rxfifo_i_pop           (rxfifo_pop),
    .rxfifo_i_empty         (rxfifo_empty),
    .dbg_rxfifo_i_numfilled (rxfifo_numfilled),
    .rxfifo_i_push          (link_push),
    .tx_i_credit            (tx_credit)
  );

  ll_cfg_regs i_cfg_regs (
    .clk_wr           (clk_wr),
    .rst_wr_n         (rst_wr_n),
    .cfg_req          (cfg_req),
    .cfg_wr           (cfg_wr),
    .cfg_addr         (cfg_addr),
    .cfg_wdata        (cfg_wdata),
    .cfg_ack          (cfg_ack),
    .cfg_rdata        (cfg_rdata),
    .credit_count     (credit_count),
    .rxfifo_numfilled (rxfifo_numfilled),
    .rxfifo_overflow  (rxfifo_overflow),
    .link_en          (link_en),
    .credit_init      (credit_init)
  );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
/*
  Testbench clock and reset generator
  Free-running 8 ns clock, reset held low for the first 10 cycles
*/
`default_nettype none

module tb_clkgen (
  output logic clk_wr,
  output logic rst_wr_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 4;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_wr = 1'b0;
    forever #(HALF_PERIOD) clk_wr = ~clk_wr;
  end

  // Release on a falling edge, away from any sampling edge
  initial begin
    rst_wr_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_wr);
    @(negedge clk_wr);
    rst_wr_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_ll_link_top.sv
/*
  Logic link testbench
  Runs a table of phases (credits, word count, downstream ready pattern)
  through the looped-back link, with a queue scoreboard on the receive
  side, four-phase register accesses and a watchdog
*/
`default_nettype none

module tb_ll_link_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SEED = 10824;
  localparam int RDY_HIGH = 0;
  localparam int RDY_LOW = 1;
  localparam int RDY_RAND = 2;
  localparam int ACK_LIMIT = 20;
  localparam int DRAIN_LIMIT = 400;

  ////////////////////////////////////////////////////////////
  // Stimulus table with one row per phase
  ////////////////////////////////////////////////////////////

  // Rows are ordered delivery, credit limit, corner case and overflow
  localparam int N_ROWS = 4;
  localparam int ROW_CREDIT [N_ROWS] = '{16, 4, 16, 20};
  localparam int ROW_WORDS [N_ROWS] = '{40, 4, 30, 20};
  localparam int ROW_READY [N_ROWS] = '{RDY_HIGH, RDY_LOW, RDY_RAND, RDY_LOW};

  logic        clk_wr;
  logic        rst_wr_n;
  logic        user_o_valid;
  logic [31:0] user_o_data;
  logic        user_o_ready;
  logic        user_i_valid;
  logic [31:0] user_i_data;
  logic        user_i_ready;
  logic        cfg_req;
  logic        cfg_wr;
  logic [1:0]  cfg_addr;
  logic [31:0] cfg_wdata;
  logic        cfg_ack;
  logic [31:0] cfg_rdata;

  int          seed = SEED;
  int          ready_seed = SEED + 7;
  int          rdy_mode = RDY_LOW;
  int          errors = 0;
  int          rx_count = 0;
  int          exp_delivered = 0;
  logic [31:0] exp_q [$];

  tb_clkgen i_clkgen (.clk_wr(clk_wr), .rst_wr_n(rst_wr_n));

  ll_link_top i_dut (
    .clk_wr       (clk_wr),
    .rst_wr_n     (rst_wr_n),
    .user_o_valid (user_o_valid),
    .user_o_data  (user_o_data),
    .user_o_ready (user_o_ready),
    .user_i_valid (user_i_valid),
    .user_i_data  (user_i_data),
    .user_i_ready (user_i_ready),
    .cfg_req      (cfg_req),
    .cfg_wr       (cfg_wr),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_ack      (cfg_ack),
    .cfg_rdata    (cfg_rdata)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  function automatic int total_words();
    int sum;
    int r;
    sum = 0;
    for (r = 0; r < N_ROWS; r++) begin
      sum += ROW_WORDS[r];
    end
    return sum;
  endfunction

  ////////////////////////////////////////////////////////////
  // Four-phase req/ack register host
  ////////////////////////////////////////////////////////////

  task automatic reg_access(input logic wr, input logic [1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk_wr);
    cfg_req   <= 1'b1;
    cfg_wr    <= wr;
    cfg_addr  <= addr;
    cfg_wdata <= wdata;
    // The block needs a capture edge first, so ack cannot be up yet
    @(negedge clk_wr);
    check_value("cfg_ack", 32'd0, 32'(cfg_ack));
    while (!cfg_ack && waited < ACK_LIMIT) begin
      @(negedge clk_wr);
      waited++;
    end
    if (!cfg_ack) begin
      errors++;
      $display("Register access to address %0d was never acknowledged", addr);
    end
    rdata = cfg_rdata;
    @(posedge clk_wr);
    cfg_req <= 1'b0;
    // Ack must still be high until the block has seen req low
    @(negedge clk_wr);
    check_value("cfg_ack", 32'd1, 32'(cfg_ack));
    waited = 0;
    while (cfg_ack && waited < ACK_LIMIT) begin
      @(negedge clk_wr);
      waited++;
    end
    if (cfg_ack) begin
      errors++;
      $display("cfg_ack stayed high after cfg_req was dropped");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Upstream driver
  ////////////////////////////////////////////////////////////

  // Accepts are seen on the falling edge and booked on the next rising
  // edge. Words past the FIFO depth are lost when nobody drains it
  task automatic send_words(input int count, input int mode);
    int          sent;
    logic        took;
    logic [31:0] word;
    sent = 0;
    word = $random(seed);
    @(posedge clk_wr);
    user_o_valid <= 1'b1;
    user_o_data  <= word;
    while (sent < count) begin
      @(negedge clk_wr);
      took = user_o_valid && user_o_ready;
      @(posedge clk_wr);
      if (took) begin
        if (mode != RDY_LOW || sent < ll_pkg::FIFO_DEPTH) begin
          exp_q.push_back(word);
        end
        sent++;
        word = $random(seed);
        user_o_data <= word;
        // Random mode leaves idle gaps so single words meet a pop
        user_o_valid <= (sent < count) && !(mode == RDY_RAND && word[0]);
      end else begin
        user_o_valid <= (sent < count);
      end
    end
  endtask

  task automatic run_phase(input int row);
    logic [31:0] rd;
    int          credit;
    int          words;
    int          mode;
    int          kept;
    int          waited;
    int          i;
    credit = ROW_CREDIT[row];
    words = ROW_WORDS[row];
    mode = ROW_READY[row];
    kept = (mode == RDY_LOW && words > ll_pkg::FIFO_DEPTH) ? ll_pkg::FIFO_DEPTH : words;
    $display("Phase %0d: %0d credits, %0d words, ready mode %0d", row, credit, words, mode);
    // Link down while the credit pool is loaded
    reg_access(1'b1, ll_pkg::REG_CTRL, 32'd0, rd);
    reg_access(1'b1, ll_pkg::REG_CREDIT, credit, rd);
    reg_access(1'b0, ll_pkg::REG_CREDIT, 32'd0, rd);
    check_value("REG_CREDIT", credit, rd);
    reg_access(1'b1, ll_pkg::REG_CTRL, 32'd1, rd);
    reg_access(1'b0, ll_pkg::REG_CTRL, 32'd0, rd);
    check_value("REG_CTRL", 32'd1, rd);
    @(negedge clk_wr);
    rdy_mode = mode;
    send_words(words, mode);
    if (mode == RDY_LOW) begin
      // With the pool spent, a further word must stay in front of the link
      @(posedge clk_wr);
      user_o_valid <= 1'b1;
      user_o_data  <= $random(seed);
      for (i = 0; i < 10; i++) begin
        @(negedge clk_wr);
        check_value("user_o_ready", 32'd0, 32'(user_o_ready));
      end
      @(posedge clk_wr);
      user_o_valid <= 1'b0;
      reg_access(1'b0, ll_pkg::REG_STATUS, 32'd0, rd);
      check_value("status credits", credit - words,
                  32'(rd[ll_pkg::STAT_CREDIT_LSB +: ll_pkg::CREDIT_WIDTH]));
      check_value("status fill", kept,
                  32'(rd[ll_pkg::STAT_FILL_LSB +: ll_pkg::FIFO_COUNT_MSB + 1]));
      check_value("status overflow", 32'(words > ll_pkg::FIFO_DEPTH),
                  32'(rd[ll_pkg::STAT_OVF_BIT]));
    end
    @(negedge clk_wr);
    rdy_mode = RDY_HIGH;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk_wr);
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Phase %0d: %0d words never reached the receiver", row, exp_q.size());
    end
    exp_delivered += kept;
    repeat (4) @(posedge clk_wr);
    // Every pop hands one credit back to the transmitter
    reg_access(1'b0, ll_pkg::REG_STATUS, 32'd0, rd);
    check_value("status fill", 32'd0,
                32'(rd[ll_pkg::STAT_FILL_LSB +: ll_pkg::FIFO_COUNT_MSB + 1]));
    check_value("status credits", credit - words + kept,
                32'(rd[ll_pkg::STAT_CREDIT_LSB +: ll_pkg::CREDIT_WIDTH]));
    // Only words dropped at a full FIFO leave the sticky flag set
    check_value("status overflow", 32'(kept != words), 32'(rd[ll_pkg::STAT_OVF_BIT]));
    if (kept != words) begin
      reg_access(1'b1, ll_pkg::REG_STATUS, 32'd0, rd);
      reg_access(1'b0, ll_pkg::REG_STATUS, 32'd0, rd);
      check_value("status overflow", 32'd0, 32'(rd[ll_pkg::STAT_OVF_BIT]));
    end
  endtask

  // Downstream ready pattern for the current phase
  initial begin
    logic [31:0] rnd;
    user_i_ready = 1'b0;
    forever begin
      @(posedge clk_wr);
      rnd = $random(ready_seed);
      case (rdy_mode)
        RDY_HIGH: user_i_ready <= 1'b1;
        RDY_RAND: user_i_ready <= rnd[0];
        default: user_i_ready <= 1'b0;
      endcase
    end
  end

  // Scoreboard that checks each transfer on the falling edge before it completes
  initial begin
    logic [31:0] head;
    forever begin
      @(negedge clk_wr);
      if (rst_wr_n && user_i_valid && user_i_ready) begin
        rx_count++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("At %0t ns word %h arrived with nothing outstanding", $time, user_i_data);
        end else begin
          head = exp_q.pop_front();
          check_value("user_i_data", head, user_i_data);
        end
      end
    end
  end

  initial begin
    int limit;
    limit = total_words() * 40 + 2000;
    repeat (limit) @(posedge clk_wr);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    int          row;
    user_o_valid = 1'b0;
    user_o_data  = '0;
    cfg_req      = 1'b0;
    cfg_wr       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    wait (rst_wr_n === 1'b1);
    repeat (2) @(posedge clk_wr);
    // Reset values of the register block
    reg_access(1'b0, ll_pkg::REG_CREDIT, 32'd0, rd);
    check_value("REG_CREDIT", 32'(ll_pkg::RESET_CREDIT), rd);
    reg_access(1'b0, ll_pkg::REG_CTRL, 32'd0, rd);
    check_value("REG_CTRL", 32'd0, rd);
    for (row = 0; row < N_ROWS; row++) begin
      run_phase(row);
    end
    repeat (5) @(posedge clk_wr);
    check_value("words received", exp_delivered, rx_count);
    $display("Done: %0d errors, %0d words received", errors, rx_count);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ll_link_top.f
ll_pkg.sv
ll_tx_ctrl.sv
ll_rx_fifo.sv
ll_rx_ctrl.sv
ll_cfg_regs.sv
ll_link_top.sv
tb_clkgen.sv
tb_ll_link_top.sv

// File: run.sh
#!/bin/sh
# Build the logic link testbench with Verilator, run it and check the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
  --top-module tb_ll_link_top -f ll_link_top.f || { echo "Build failed"; exit 1; }
out=$(./obj_dir/Vtb_ll_link_top 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED" &&
  echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
